/* bench/icap_cfg_model.sv */
// Configuration port model with sync tracking, packet decode and a 32-entry register file
`timescale 1ns/10ps
`include "icap_params.svh"

module icap_cfg_model
	import icap_pkg::*;
(
	input  icap_pins_t  i_pins,
	output logic [31:0] o_data
);

	logic [31:0] regs [32];
	logic        slow_clk;
	logic        synced;
	logic        expect_data;
	logic        read_active;
	logic [4:0]  wr_addr;
	logic [4:0]  rd_addr;
	int          read_cycles;
	int          hdr_count;
	// First header of the latest sequence, looked at by the bench
	logic [1:0]  req_op;
	logic [4:0]  req_addr;
	logic [31:0] req_wdata;
	int          seq_done;
	int          order_errors;

	// Port wiring swaps bit order inside each byte
	function automatic logic [31:0] swap_bits_in_bytes(input logic [31:0] w);
		logic [31:0] r;
		for (int i = 0; i < 32; i++) begin
			r[i] = w[i ^ 7];
		end
		return r;
	endfunction

	// Power-up image, every address bit shows up in the word
	initial begin
		for (int a = 0; a < 32; a++) begin
			regs[a] = {3'b000, a[4:0], 8'h5a, ~{3'b000, a[4:0]}, 8'hc3 ^ {a[4:0], 3'b000}};
		end
		synced       = 1'b0;
		expect_data  = 1'b0;
		read_active  = 1'b0;
		wr_addr      = '0;
		rd_addr      = '0;
		read_cycles  = 0;
		hdr_count    = 0;
		req_op       = '0;
		req_addr     = '0;
		req_wdata    = '0;
		seq_done     = 0;
		order_errors = 0;
	end

	assign slow_clk = i_pins.clk;

	////////////////////////////////////////////////////////////////////////////
	// Word decode on the rising port clock
	////////////////////////////////////////////////////////////////////////////

	always @(posedge slow_clk) begin
		icap_word_u w;
		w.raw = swap_bits_in_bytes(i_pins.data);
		if (!i_pins.cs_n && i_pins.rdwr_n) begin
			// Read cycle, port drives the bus
			if (!read_active) begin
				order_errors++;
				$display("Model: read cycle seen without a read header before it");
			end
			read_cycles++;
		end else if (!i_pins.cs_n) begin
			// Back in write mode ends a read
			if (read_active && read_cycles != 0) begin
				read_active = 1'b0;
			end
			if (expect_data) begin
				expect_data   = 1'b0;
				regs[wr_addr] = w.raw;
				if (hdr_count == 1)
					req_wdata = w.raw;
				// DESYNC command to CMD
				if (wr_addr == 5'd4 && w.raw == `ICAP_DESYNC_CMD) begin
					synced = 1'b0;
					seq_done++;
				end
			end else if (w.raw == `ICAP_NOOP || w.raw == `ICAP_DUMMY) begin
				// Padding words carry nothing
			end else if (!synced) begin
				if (w.raw == `ICAP_SYNC) begin
					synced    = 1'b1;
					hdr_count = 0;
				end else begin
					order_errors++;
					$display("Model: word %h arrived before the sync word", w.raw);
				end
			end else if (w.hdr.typ != 3'b001 || w.hdr.count != 11'd1) begin
				order_errors++;
				$display("Model: word %h is not a one-word type-1 header", w.raw);
			end else begin
				hdr_count++;
				if (hdr_count == 1) begin
					req_op   = w.hdr.op;
					req_addr = w.hdr.addr;
				end
				if (w.hdr.op == `ICAP_OP_WRITE) begin
					expect_data = 1'b1;
					wr_addr     = w.hdr.addr;
				end else if (w.hdr.op == `ICAP_OP_READ) begin
					read_active = 1'b1;
					read_cycles = 0;
					rd_addr     = w.hdr.addr;
				end else begin
					order_errors++;
					$display("Model: header %h has an unknown opcode", w.raw);
				end
			end
		end
	end

	// Addressed register while the port is read
	assign o_data = (read_active && !i_pins.cs_n && i_pins.rdwr_n) ?
		swap_bits_in_bytes(regs[rd_addr]) : 32'hffff_ffff;

endmodule

/* bench/tb_icap_bridge.sv */
// Bridge testbench with clock, reset, LFSR stimulus, register model, checks and timeout
`timescale 1ns/10ps
`include "icap_params.svh"

module tb_icap_bridge
	import icap_pkg::*;
();

	localparam int STEP_CYCLES = 1 << `ICAP_LGDIV;
	localparam int N_WRITES    = 24;
	localparam int N_PARTIAL   = 8;
	localparam int N_READS     = 24;
	localparam int N_DROPS     = 6;
	// 80 requests of up to 24 steps with slack
	localparam int TIMEOUT_CYCLES = 80 * 24 * STEP_CYCLES + 40 * STEP_CYCLES;

	logic        clk;
	logic        reset;
	bus_req_t    bus;
	bus_rsp_t    rsp;
	icap_pins_t  pins;
	logic [31:0] port_data;
	logic [31:0] lfsr;
	logic [31:0] regs_exp [32];
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          seq_exp = 0;

	icap_bridge_top DUT (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_bus       (bus),
		.o_bus       (rsp),
		.o_icap      (pins),
		.i_icap_data (port_data)
	);

	icap_cfg_model u_cfg_model (
		.i_pins (pins),
		.o_data (port_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the bridge stopped returning to idle", cycles);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus source and checks
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("%s", what);
	endtask

	// Issue one request and follow it until the slave is idle again
	task automatic run_request(
		input  logic        we,
		input  logic [4:0]  addr,
		input  logic [31:0] wdata,
		input  logic [3:0]  sel,
		input  int          drop_after,
		output logic [31:0] rdata,
		output int          acks
	);
		int n;
		bit idle;
		rdata = '0;
		acks  = 0;
		n     = 0;
		idle  = 1'b0;
		bus.stb  <= 1'b1;
		bus.we   <= we;
		bus.addr <= addr;
		bus.data <= wdata;
		bus.sel  <= sel;
		// Taken on the edge where stall is low
		do begin
			@(posedge clk);
			if (rsp.ack)
				report_error("Ack arrived while no request was outstanding");
		end while (rsp.stall);
		bus.stb <= 1'b0;
		while (!idle) begin
			@(posedge clk);
			n++;
			if (rsp.ack) begin
				acks++;
				rdata = rsp.data;
			end
			if (!(&sel) && !pins.cs_n)
				report_error("Port was selected during a partial-select request");
			if (n == drop_after)
				bus.cyc <= 1'b0;
			// Stall only drops in idle
			if (!rsp.stall)
				idle = 1'b1;
		end
		bus.cyc <= 1'b1;
	endtask

	task automatic full_access(input logic we, input logic [4:0] addr,
		input logic [31:0] wdata, input int drop_after);
		logic [31:0] rdata;
		logic [31:0] exp_rd;
		logic [1:0]  exp_op;
		int          acks;
		exp_rd = regs_exp[addr];
		exp_op = we ? `ICAP_OP_WRITE : `ICAP_OP_READ;
		run_request(we, addr, wdata, 4'hf, drop_after, rdata, acks);
		// Sequence always finishes and DESYNC lands in CMD
		if (we)
			regs_exp[addr] = wdata;
		regs_exp[4] = `ICAP_DESYNC_CMD;
		seq_exp++;
		check_value("ack_count", acks, (drop_after < 0) ? 1 : 0);
		if (!we && drop_after < 0)
			check_value("o_bus.data", rdata, exp_rd);
		check_value("seq_done", u_cfg_model.seq_done, seq_exp);
		check_value("hdr.op", 32'(u_cfg_model.req_op), 32'(exp_op));
		check_value("hdr.addr", 32'(u_cfg_model.req_addr), 32'(addr));
		if (we)
			check_value("hdr.wdata", u_cfg_model.req_wdata, wdata);
	endtask

	task automatic partial_access(input logic we, input logic [4:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel);
		logic [31:0] rdata;
		int          acks;
		run_request(we, addr, wdata, sel, -1, rdata, acks);
		check_value("ack_count", acks, 1);
		check_value("o_bus.data", rdata, 32'h0);
		check_value("seq_done", u_cfg_model.seq_done, seq_exp);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] w;
		logic [31:0] s;
		logic [31:0] k;
		int          n;
		lfsr   = 32'h4960;
		reset <= 1'b1;
		bus   <= '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		// Start from the port's power-up image
		for (int i = 0; i < 32; i++) begin
			regs_exp[i] = u_cfg_model.regs[i];
		end
		@(posedge clk);
		check_value("o_bus.ack", 32'(rsp.ack), 32'h0);
		check_value("o_icap.cs_n", 32'(pins.cs_n), 32'h1);
		check_value("o_icap.rdwr_n", 32'(pins.rdwr_n), 32'h1);
		check_value("o_icap.clk", 32'(pins.clk), 32'h0);
		check_value("o_icap.data", pins.data, 32'hffff_ffff);
		check_value("o_bus.stall", 32'(rsp.stall), 32'h1);
		// First idle strobe opens the bus
		n = 0;
		while (rsp.stall && n <= STEP_CYCLES) begin
			@(posedge clk);
			n++;
		end
		if (rsp.stall)
			report_error("Stall stayed high through the first strobe after reset");
		bus.cyc <= 1'b1;

		for (int i = 0; i < N_WRITES; i++) begin
			draw_bits(5, a);
			draw_bits(32, d);
			full_access(1'b1, a[4:0], d, -1);
		end
		// At least one select bit cleared
		for (int i = 0; i < N_PARTIAL; i++) begin
			draw_bits(1, w);
			draw_bits(5, a);
			draw_bits(32, d);
			draw_bits(4, s);
			draw_bits(2, k);
			s[k[1:0]] = 1'b0;
			partial_access(w[0], a[4:0], d, s[3:0]);
		end
		for (int i = 0; i < N_READS; i++) begin
			draw_bits(5, a);
			full_access(1'b0, a[4:0], 32'h0, -1);
		end
		// Cyc dropped mid-sequence and the address read back
		for (int i = 0; i < N_DROPS; i++) begin
			draw_bits(1, w);
			draw_bits(5, a);
			draw_bits(32, d);
			draw_bits(5, k);
			full_access(w[0], a[4:0], d, 8 + int'(k));
			full_access(1'b0, a[4:0], 32'h0, -1);
		end

		for (int i = 0; i < 32; i++) begin
			check_value("model regs", u_cfg_model.regs[i], regs_exp[i]);
		end
		$display("Checks %0d, compare errors %0d, port order errors %0d",
			checks, errors, u_cfg_model.order_errors);
		if (errors == 0 && u_cfg_model.order_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* common/icap_params.svh */
// Slow clock divide, fixed ICAP command words, opcodes and sequencer step numbers
`ifndef ICAP_PARAMS_SVH
`define ICAP_PARAMS_SVH

// Log2 of the slow port clock divide, never below 2
`define ICAP_LGDIV 3

// Fixed words sent to the configuration port
`define ICAP_DUMMY      32'hffff_ffff
`define ICAP_NOOP       32'h2000_0000
`define ICAP_SYNC       32'haa99_5566
// Type-1 write of one word to CMD (register 4)
`define ICAP_DESYNC_HDR 32'h3000_8001
`define ICAP_DESYNC_CMD 32'h0000_000d

// Opcode field of a type-1 header
`define ICAP_OP_READ  2'b01
`define ICAP_OP_WRITE 2'b10

// Step numbers where the sequence branches or rejoins
`define ICAP_STEP_IDLE      5'h00
`define ICAP_STEP_SYNC_END  5'h05
`define ICAP_STEP_READ      5'h06
`define ICAP_STEP_READ_END  5'h0e
`define ICAP_STEP_WRITE     5'h0f
`define ICAP_STEP_WRITE_END 5'h10
`define ICAP_STEP_DESYNC    5'h11
// Final step, acks a write and returns to idle
`define ICAP_STEP_LAST      5'h17

`endif

/* common/icap_pkg.sv */
// Bus request and response structs, ICAP header, word union, pin struct and step type
package icap_pkg;

	// One pipelined bus request, as seen by the slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
		logic [3:0]  sel;
	} bus_req_t;

	// Slave response, stall is the only flow control
	typedef struct packed {
		logic        stall;
		logic        ack;
		logic [31:0] data;
	} bus_rsp_t;

	// Type-1 configuration packet header
	typedef struct packed {
		logic [2:0]  typ;
		logic [1:0]  op;
		logic [8:0]  rsvd_hi;
		logic [4:0]  addr;
		logic [1:0]  rsvd_lo;
		logic [10:0] count;
	} icap_hdr_t;

	// Port word, either a header or a raw data/command word
	typedef union packed {
		icap_hdr_t   hdr;
		logic [31:0] raw;
	} icap_word_u;

	// Pins towards the configuration port
	typedef struct packed {
		logic        clk;
		logic        cs_n;
		logic        rdwr_n;
		// Bit-reversed within each byte
		logic [31:0] data;
	} icap_pins_t;

	typedef logic [4:0] seq_step_t;

endpackage

/* icap_seq/icap_port.sv */
// ICAP pin registers, per-byte bit reversal both ways and read data capture
`timescale 1ns/10ps
`include "icap_params.svh"

module icap_port
	import icap_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_slow_clk,
	input  icap_word_u  i_word,
	input  logic        i_cs_n,
	input  logic        i_rdwr_n,
	input  logic        i_capture,
	input  logic [31:0] i_icap_data,
	output icap_pins_t  o_icap,
	output logic [31:0] o_rd_data
);

	icap_pins_t  r_pins;
	logic [31:0] rd_rev;
	logic [31:0] r_rd_data;

	// Port bit order is reversed inside every byte
	function automatic logic [31:0] byte_bitrev(input logic [31:0] w);
		logic [31:0] r;
		for (int b = 0; b < 4; b++) begin
			for (int k = 0; k < 8; k++) begin
				r[8*b+k] = w[8*b+7-k];
			end
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Outgoing pins
	////////////////////////////////////////////////////////////////////////////

	// Slow clock goes through the same register stage, so data still
	// changes half a slow period ahead of the rising edge
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_pins.clk    <= 1'b0;
			r_pins.cs_n   <= 1'b1;
			r_pins.rdwr_n <= 1'b1;
			r_pins.data   <= `ICAP_DUMMY;
		end else begin
			r_pins.clk    <= i_slow_clk;
			r_pins.cs_n   <= i_cs_n;
			r_pins.rdwr_n <= i_rdwr_n;
			r_pins.data   <= byte_bitrev(i_word.raw);
		end
	end

	assign o_icap = r_pins;

	////////////////////////////////////////////////////////////////////////////
	// Read return
	////////////////////////////////////////////////////////////////////////////

	assign rd_rev = byte_bitrev(i_icap_data);

	// Held until the next read end
	always_ff @(posedge i_clk) begin
		if (i_capture)
			r_rd_data <= rd_rev;
	end

	assign o_rd_data = r_rd_data;

endmodule

/* icap_seq/icap_sequencer.sv */
// ICAP step machine with bus intake, command sequence, ack and pending tracking
`timescale 1ns/10ps
`include "icap_params.svh"

module icap_sequencer
	import icap_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_step_stb,
	input  bus_req_t    i_bus,
	input  logic [31:0] i_rd_data,
	output bus_rsp_t    o_bus,
	output icap_word_u  o_word,
	output logic        o_cs_n,
	output logic        o_rdwr_n,
	output logic        o_capture
);

	localparam logic [2:0] HDR_TYPE1 = 3'b001;

	seq_step_t   r_step;
	icap_word_u  r_word;
	logic        r_cs_n;
	logic        r_rdwr_n;
	logic        r_ack;
	logic        r_ack_rd;
	logic        r_pending;
	// Latched request
	logic        r_we;
	logic [4:0]  r_addr;
	logic [31:0] r_data;
	logic        take;
	logic        full_sel;

	// Single-word type-1 header for the given opcode and register
	function automatic icap_word_u make_hdr(
		input logic [1:0] op,
		input logic [4:0] addr
	);
		icap_word_u w;
		w.hdr.typ     = HDR_TYPE1;
		w.hdr.op      = op;
		w.hdr.rsvd_hi = '0;
		w.hdr.addr    = addr;
		w.hdr.rsvd_lo = '0;
		w.hdr.count   = 11'd1;
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Request intake
	////////////////////////////////////////////////////////////////////////////

	// Only open on a strobe in idle
	assign take     = i_bus.stb && i_step_stb && (r_step == `ICAP_STEP_IDLE);
	assign full_sel = &i_bus.sel;

	always_ff @(posedge i_clk) begin
		if (take) begin
			r_we   <= i_bus.we;
			r_addr <= i_bus.addr;
			r_data <= i_bus.data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Step machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_step     <= `ICAP_STEP_IDLE;
			r_word.raw <= `ICAP_DUMMY;
			r_cs_n     <= 1'b1;
			r_rdwr_n   <= 1'b1;
			r_ack      <= 1'b0;
			r_ack_rd   <= 1'b0;
			r_pending  <= 1'b0;
		end else begin
			// Ack is a single-cycle pulse
			r_ack    <= 1'b0;
			r_ack_rd <= 1'b0;
			// Dropping cyc abandons the request, the sequence still runs
			r_pending <= r_pending && i_bus.cyc;

			if (i_step_stb) begin
				r_step <= r_step + 5'd1;
				case (r_step)
					`ICAP_STEP_IDLE: begin
						r_cs_n     <= 1'b1;
						r_rdwr_n   <= 1'b1;
						r_word.raw <= `ICAP_DUMMY;
						r_step     <= `ICAP_STEP_IDLE;
						// Partial word, answer zero at once
						r_ack      <= take && !full_sel;
						if (take && full_sel) begin
							r_step    <= r_step + 5'd1;
							r_pending <= 1'b1;
						end
					end
					5'h01: begin
						// Dummy word, port still deselected
						r_cs_n     <= 1'b1;
						r_word.raw <= `ICAP_DUMMY;
					end
					5'h02: begin
						// Select port for writing
						r_cs_n     <= 1'b0;
						r_rdwr_n   <= 1'b0;
						r_word.raw <= `ICAP_NOOP;
					end
					5'h03: r_word.raw <= `ICAP_SYNC;
					5'h04: r_word.raw <= `ICAP_NOOP;
					`ICAP_STEP_SYNC_END: begin
						// Branch by direction
						r_word.raw <= `ICAP_NOOP;
						r_step     <= r_we ? `ICAP_STEP_WRITE : `ICAP_STEP_READ;
					end

					// Read branch
					`ICAP_STEP_READ: r_word <= make_hdr(`ICAP_OP_READ, r_addr);
					5'h07, 5'h08: r_word.raw <= `ICAP_NOOP;
					5'h09: begin
						// Idle gap before turning the bus around
						r_cs_n     <= 1'b1;
						r_rdwr_n   <= 1'b1;
						r_word.raw <= `ICAP_NOOP;
					end
					5'h0a, 5'h0b, 5'h0c, 5'h0d: begin
						// Four wait cycles selected for reading
						r_cs_n     <= 1'b0;
						r_rdwr_n   <= 1'b1;
						r_word.raw <= `ICAP_NOOP;
					end
					`ICAP_STEP_READ_END: begin
						// Result captured now, ack with it
						r_cs_n     <= 1'b1;
						r_rdwr_n   <= 1'b1;
						r_word.raw <= `ICAP_NOOP;
						r_ack      <= r_pending && i_bus.cyc;
						r_ack_rd   <= 1'b1;
						r_pending  <= 1'b0;
						r_step     <= `ICAP_STEP_DESYNC;
					end

					// Write branch
					`ICAP_STEP_WRITE: r_word <= make_hdr(`ICAP_OP_WRITE, r_addr);
					// Data word goes out as is
					`ICAP_STEP_WRITE_END: r_word.raw <= r_data;

					// Common tail
					`ICAP_STEP_DESYNC: begin
						r_cs_n     <= 1'b0;
						r_rdwr_n   <= 1'b0;
						r_word.raw <= `ICAP_NOOP;
					end
					5'h12: r_word.raw <= `ICAP_NOOP;
					5'h13: r_word.raw <= `ICAP_DESYNC_HDR;
					5'h14: r_word.raw <= `ICAP_DESYNC_CMD;
					5'h15, 5'h16: r_word.raw <= `ICAP_NOOP;
					`ICAP_STEP_LAST: begin
						// Release port, ack a write still pending
						r_cs_n     <= 1'b1;
						r_rdwr_n   <= 1'b1;
						r_word.raw <= `ICAP_DUMMY;
						r_ack      <= r_pending && i_bus.cyc;
						r_pending  <= 1'b0;
						r_step     <= `ICAP_STEP_IDLE;
					end
					default: begin
						// Unused step numbers fall back to idle
						r_cs_n     <= 1'b1;
						r_rdwr_n   <= 1'b1;
						r_word.raw <= `ICAP_DUMMY;
						r_pending  <= 1'b0;
						r_step     <= `ICAP_STEP_IDLE;
					end
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	// Stalled everywhere but the idle strobe
	always_comb begin
		o_bus.stall = !(i_step_stb && (r_step == `ICAP_STEP_IDLE));
		o_bus.ack   = r_ack;
		// Read register is loaded on the same edge the ack rises
		o_bus.data  = r_ack_rd ? i_rd_data : 32'h0;
	end

	assign o_capture = i_step_stb && (r_step == `ICAP_STEP_READ_END);
	assign o_word    = r_word;
	assign o_cs_n    = r_cs_n;
	assign o_rdwr_n  = r_rdwr_n;

endmodule

/* logic/icap_bridge_top.sv */
// Bus to ICAP bridge top with divider, sequencer and port stage instances
`timescale 1ns/10ps

module icap_bridge_top
	import icap_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_reset,
	input  bus_req_t    i_bus,
	output bus_rsp_t    o_bus,
	output icap_pins_t  o_icap,
	input  logic [31:0] i_icap_data
);

	// Divider outputs
	logic        slow_clk;
	logic        step_stb;
	// Sequencer to port stage
	icap_word_u  seq_word;
	logic        seq_cs_n;
	logic        seq_rdwr_n;
	logic        seq_capture;
	// Captured read word back to the sequencer
	logic [31:0] rd_data;

	icap_clk_div u_clk_div (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.o_slow_clk (slow_clk),
		.o_step_stb (step_stb)
	);

	icap_sequencer u_sequencer (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_step_stb (step_stb),
		.i_bus      (i_bus),
		.i_rd_data  (rd_data),
		.o_bus      (o_bus),
		.o_word     (seq_word),
		.o_cs_n     (seq_cs_n),
		.o_rdwr_n   (seq_rdwr_n),
		.o_capture  (seq_capture)
	);

	icap_port u_port (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_slow_clk  (slow_clk),
		.i_word      (seq_word),
		.i_cs_n      (seq_cs_n),
		.i_rdwr_n    (seq_rdwr_n),
		.i_capture   (seq_capture),
		.i_icap_data (i_icap_data),
		.o_icap      (o_icap),
		.o_rd_data   (rd_data)
	);

endmodule

/* logic/icap_clk_div.sv */
// Free-running divider for the slow ICAP clock and the one-cycle step strobe
`timescale 1ns/10ps
`include "icap_params.svh"

module icap_clk_div (
	input  logic i_clk,
	input  logic i_reset,
	output logic o_slow_clk,
	output logic o_step_stb
);

	localparam int LGDIV = `ICAP_LGDIV;
	// All ones minus one, strobe lands on the all-ones count
	localparam logic [LGDIV-1:0] STB_CNT = {{(LGDIV-1){1'b1}}, 1'b0};

	logic [LGDIV-1:0] r_count;
	logic             r_stb;

	// Counter and strobe
	// Strobe is high while the count is all ones, so steps move on the wrap,
	// which is the falling edge of the slow clock
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_count <= '0;
			r_stb   <= 1'b0;
		end else begin
			r_count <= r_count + 1'b1;
			r_stb   <= (r_count == STB_CNT);
		end
	end

	// Top bit is the port clock, rising half a period after the wrap
	assign o_slow_clk = r_count[LGDIV-1];
	assign o_step_stb = r_stb;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the bridge testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing \
	--top-module tb_icap_bridge \
	-Mdir build/obj -o sim \
	-f src.f

./build/obj/sim > build/sim.log 2>&1
cat build/sim.log

if grep -q "Errors found" build/sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation passed"
exit 0

/* src.f */
+incdir+common
common/icap_pkg.sv
logic/icap_clk_div.sv
icap_seq/icap_sequencer.sv
icap_seq/icap_port.sv
logic/icap_bridge_top.sv
bench/icap_cfg_model.sv
bench/tb_icap_bridge.sv
